// File: source/rsa_pkg.sv
package rsa_pkg;

	// operand width for a 256-bit modulus
	localparam int RSA_W = 256;

	// counters must reach 256, hence one extra bit
	localparam int CNT_W = 9;

	// core controller states
	typedef enum logic [2:0] {
		S_IDLE,   // waiting for a start strobe
		S_PREP,   // converting a into montgomery form
		S_LAUNCH, // issue start to the multipliers
		S_MONT,   // multipliers busy
		S_UPDATE  // move results into t and m
	} core_state_t;

	// shared by the preparation unit and the multiplier
	typedef enum logic [1:0] {
		U_IDLE,
		U_RUN,
		U_FIX     // final conditional subtraction
	} unit_state_t;

endpackage

// File: source/rsa_mod_prep.sv
`timescale 1ns/10ps

module rsa_mod_prep (
	input  logic                      i_clk,
	input  logic                      i_rst,
	input  logic                      i_start,
	input  logic [rsa_pkg::RSA_W-1:0] i_n,
	input  logic [rsa_pkg::RSA_W-1:0] i_a,
	output logic [rsa_pkg::RSA_W-1:0] o_t,
	output logic                      o_done
);
	import rsa_pkg::*;

	unit_state_t      state_r;
	logic [CNT_W-1:0] cnt_r;     // doubling steps taken
	logic             done_r;
	logic [RSA_W:0]   acc_r;     // one spare bit for the doubling
	logic [RSA_W-1:0] n_r;
	logic [RSA_W:0]   dbl;
	logic [RSA_W:0]   step;

	// acc stays below n, so its top bit is always clear before doubling
	assign dbl = {acc_r[RSA_W-1:0], 1'b0};

	always_comb begin
		if (dbl >= {1'b0, n_r}) begin
			step = dbl - {1'b0, n_r};
		end else begin
			step = dbl;
		end
	end

	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			state_r <= U_IDLE;
			cnt_r   <= '0;
			done_r  <= 1'b0;
		end else begin
			done_r <= 1'b0;
			case (state_r)
				U_IDLE: begin
					if (i_start) begin
						state_r <= U_RUN;
						cnt_r   <= '0;
					end
				end
				U_RUN: begin
					cnt_r <= cnt_r + 1'b1;
					if (cnt_r == CNT_W'(RSA_W - 1)) begin
						state_r <= U_FIX; // 256th doubling this cycle
					end
				end
				U_FIX: begin
					state_r <= U_IDLE;
					done_r  <= 1'b1;
				end
				default: state_r <= U_IDLE;
			endcase
		end
	end

	// datapath
	always_ff @(posedge i_clk) begin
		if (state_r == U_IDLE && i_start) begin
			acc_r <= {1'b0, i_a};
			n_r   <= i_n;
		end else if (state_r == U_RUN) begin
			acc_r <= step; // 2*acc mod n
		end
		if (state_r == U_FIX) begin
			o_t <= acc_r[RSA_W-1:0]; // already reduced by every step
		end
	end

	assign o_done = done_r;

endmodule

// File: source/rsa_mont_mult.sv
`timescale 1ns/10ps

module rsa_mont_mult (
	input  logic                      i_clk,
	input  logic                      i_rst,
	input  logic                      i_start,
	input  logic [rsa_pkg::RSA_W-1:0] i_n,
	input  logic [rsa_pkg::RSA_W-1:0] i_a,
	input  logic [rsa_pkg::RSA_W-1:0] i_b,
	output logic [rsa_pkg::RSA_W-1:0] o_m,
	output logic                      o_done
);
	import rsa_pkg::*;

	unit_state_t      state_r;
	logic [CNT_W-1:0] cnt_r;
	logic             fix_done_r; // result written, done goes out next cycle
	logic             done_r;

	logic [RSA_W-1:0] a_r;        // shifted right, bit 0 is the current bit
	logic [RSA_W-1:0] b_r;
	logic [RSA_W-1:0] n_r;
	logic [RSA_W+1:0] s_r;        // partial sum, kept below 2n

	logic [RSA_W+1:0] sum_b;
	logic [RSA_W+1:0] sum_n;
	logic [RSA_W+1:0] s_next;
	logic [RSA_W+1:0] s_fix;

	// one radix-2 step
	always_comb begin
		if (a_r[0]) begin
			sum_b = s_r + {2'b00, b_r};
		end else begin
			sum_b = s_r;
		end
		if (sum_b[0]) begin
			sum_n = sum_b + {2'b00, n_r}; // make it even
		end else begin
			sum_n = sum_b;
		end
		s_next = sum_n >> 1;
	end

	// s < 2n at the end, so a single subtraction suffices
	always_comb begin
		if (s_r >= {2'b00, n_r}) begin
			s_fix = s_r - {2'b00, n_r};
		end else begin
			s_fix = s_r;
		end
	end

	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			state_r    <= U_IDLE;
			cnt_r      <= '0;
			fix_done_r <= 1'b0;
			done_r     <= 1'b0;
		end else begin
			fix_done_r <= 1'b0;
			done_r     <= fix_done_r;
			case (state_r)
				U_IDLE: begin
					if (i_start) begin
						state_r <= U_RUN;
						cnt_r   <= '0;
					end
				end
				U_RUN: begin
					cnt_r <= cnt_r + 1'b1;
					if (cnt_r == CNT_W'(RSA_W - 1)) begin
						state_r <= U_FIX;
					end
				end
				U_FIX: begin
					state_r    <= U_IDLE;
					fix_done_r <= 1'b1;
				end
				default: state_r <= U_IDLE;
			endcase
		end
	end

	always_ff @(posedge i_clk) begin
		if (state_r == U_IDLE && i_start) begin
			a_r <= i_a;
			b_r <= i_b;
			n_r <= i_n;
			s_r <= '0;
		end else if (state_r == U_RUN) begin
			a_r <= a_r >> 1;
			s_r <= s_next;
		end
		if (state_r == U_FIX) begin
			o_m <= s_fix[RSA_W-1:0]; // a*b*2^-256 mod n
		end
	end

	assign o_done = done_r;

endmodule

// File: source/rsa_core.sv
`timescale 1ns/10ps

module rsa_core (
	input  logic                      i_clk,
	input  logic                      i_rst,
	input  logic                      i_start,
	input  logic [rsa_pkg::RSA_W-1:0] i_a,      // ciphertext
	input  logic [rsa_pkg::RSA_W-1:0] i_d,      // private exponent
	input  logic [rsa_pkg::RSA_W-1:0] i_n,      // odd modulus
	output logic [rsa_pkg::RSA_W-1:0] o_a_pow_d, // plaintext
	output logic                      o_finished
);
	import rsa_pkg::*;

	core_state_t      state_r, state_w;
	logic             prep_start_r, prep_start_w;
	logic             sq_start_r, sq_start_w;
	logic             mul_start_r, mul_start_w;
	logic             mul_pend_r, mul_pend_w;   // multiply issued for this bit
	logic             sq_got_r, sq_got_w;
	logic             mul_got_r, mul_got_w;
	logic             finished_r, finished_w;
	logic [CNT_W-1:0] bit_cnt_r, bit_cnt_w;
	logic [RSA_W-1:0] result_r, result_w;

	logic [RSA_W-1:0] d_r, d_w;                 // exponent, shifted right per bit
	logic [RSA_W-1:0] t_r, t_w;                 // a^(2^i) in montgomery form
	logic [RSA_W-1:0] m_r, m_w;                 // running product
	logic [RSA_W-1:0] sq_res_r, sq_res_w;
	logic [RSA_W-1:0] mul_res_r, mul_res_w;

	logic [RSA_W-1:0] prep_t;
	logic             prep_done;
	logic [RSA_W-1:0] sq_m;
	logic             sq_done;
	logic [RSA_W-1:0] mul_m;
	logic             mul_done;

	logic             sq_ok;
	logic             mul_ok;

	rsa_mod_prep u_prep (
		.i_clk   (i_clk),
		.i_rst   (i_rst),
		.i_start (prep_start_r),
		.i_n     (i_n),
		.i_a     (i_a),
		.o_t     (prep_t),
		.o_done  (prep_done)
	);

	rsa_mont_mult u_mont_sq (
		.i_clk   (i_clk),
		.i_rst   (i_rst),
		.i_start (sq_start_r),
		.i_n     (i_n),
		.i_a     (t_r),
		.i_b     (t_r),
		.o_m     (sq_m),
		.o_done  (sq_done)
	);

	rsa_mont_mult u_mont_mul (
		.i_clk   (i_clk),
		.i_rst   (i_rst),
		.i_start (mul_start_r),
		.i_n     (i_n),
		.i_a     (m_r),
		.i_b     (t_r),
		.o_m     (mul_m),
		.o_done  (mul_done)
	);

	// a unit counts as finished if its done was seen earlier or is seen now
	assign sq_ok  = sq_got_r | sq_done;
	assign mul_ok = ~mul_pend_r | mul_got_r | mul_done;

	always_comb begin
		state_w      = state_r;
		prep_start_w = 1'b0; // start strobes last one cycle
		sq_start_w   = 1'b0;
		mul_start_w  = 1'b0;
		mul_pend_w   = mul_pend_r;
		sq_got_w     = sq_got_r;
		mul_got_w    = mul_got_r;
		finished_w   = 1'b0;
		bit_cnt_w    = bit_cnt_r;
		result_w     = result_r;
		d_w          = d_r;
		t_w          = t_r;
		m_w          = m_r;
		sq_res_w     = sq_res_r;
		mul_res_w    = mul_res_r;

		case (state_r)
			S_IDLE: begin
				if (i_start) begin
					d_w          = i_d;
					prep_start_w = 1'b1;
					state_w      = S_PREP;
				end
			end
			S_PREP: begin
				if (prep_done) begin
					t_w       = prep_t;
					m_w       = RSA_W'(1); // plain 1, cancels the montgomery factor
					bit_cnt_w = '0;
					state_w   = S_LAUNCH;
				end
			end
			S_LAUNCH: begin
				sq_start_w  = 1'b1;
				mul_start_w = d_r[0];
				mul_pend_w  = d_r[0];
				sq_got_w    = 1'b0;
				mul_got_w   = 1'b0;
				state_w     = S_MONT;
			end
			S_MONT: begin
				if (sq_done) begin
					sq_res_w = sq_m;
					sq_got_w = 1'b1;
				end
				if (mul_done) begin
					mul_res_w = mul_m;
					mul_got_w = 1'b1;
				end
				if (sq_ok && mul_ok) begin
					state_w = S_UPDATE;
				end
			end
			S_UPDATE: begin
				t_w = sq_res_r;
				if (mul_pend_r) begin
					m_w = mul_res_r;
				end
				d_w       = d_r >> 1;
				bit_cnt_w = bit_cnt_r + 1'b1;
				if (bit_cnt_r == CNT_W'(RSA_W - 1)) begin
					finished_w = 1'b1; // last exponent bit
					result_w   = m_w;
					state_w    = S_IDLE;
				end else begin
					state_w = S_LAUNCH;
				end
			end
			default: state_w = S_IDLE;
		endcase
	end

	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			state_r      <= S_IDLE;
			prep_start_r <= 1'b0;
			sq_start_r   <= 1'b0;
			mul_start_r  <= 1'b0;
			mul_pend_r   <= 1'b0;
			sq_got_r     <= 1'b0;
			mul_got_r    <= 1'b0;
			finished_r   <= 1'b0;
			bit_cnt_r    <= '0;
			result_r     <= '0;
		end else begin
			state_r      <= state_w;
			prep_start_r <= prep_start_w;
			sq_start_r   <= sq_start_w;
			mul_start_r  <= mul_start_w;
			mul_pend_r   <= mul_pend_w;
			sq_got_r     <= sq_got_w;
			mul_got_r    <= mul_got_w;
			finished_r   <= finished_w;
			bit_cnt_r    <= bit_cnt_w;
			result_r     <= result_w;
		end
	end

	always_ff @(posedge i_clk) begin
		d_r       <= d_w;
		t_r       <= t_w;
		m_r       <= m_w;
		sq_res_r  <= sq_res_w;
		mul_res_r <= mul_res_w;
	end

	assign o_a_pow_d  = result_r;
	assign o_finished = finished_r;

endmodule

// File: verif/rsa_core_chk.sv
`timescale 1ns/10ps

module rsa_core_chk (
	input logic i_clk,
	input logic i_rst,
	input logic i_start,
	input logic i_finished,
	input logic i_prep_start,
	input logic i_prep_done,
	input logic i_sq_start,
	input logic i_sq_done,
	input logic i_mul_start,
	input logic i_mul_done
);
	logic prep_busy_r; // between start and done of each unit
	logic sq_busy_r;
	logic mul_busy_r;
	logic seen_start_r;

	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			prep_busy_r  <= 1'b0;
			sq_busy_r    <= 1'b0;
			mul_busy_r   <= 1'b0;
			seen_start_r <= 1'b0;
		end else begin
			prep_busy_r  <= i_prep_start | (prep_busy_r & ~i_prep_done);
			sq_busy_r    <= i_sq_start | (sq_busy_r & ~i_sq_done);
			mul_busy_r   <= i_mul_start | (mul_busy_r & ~i_mul_done);
			seen_start_r <= seen_start_r | i_start;
		end
	end

	a_finish_pulse: assert property (@(posedge i_clk) disable iff (i_rst)
		i_finished |=> !i_finished)
		else $error("o_finished high for more than one cycle");

	a_start_idle_unit: assert property (@(posedge i_clk) disable iff (i_rst)
		!(i_prep_start && prep_busy_r) && !(i_sq_start && sq_busy_r)
		&& !(i_mul_start && mul_busy_r))
		else $error("start pulse sent to a unit that is still running");

	a_no_early_finish: assert property (@(posedge i_clk) disable iff (i_rst)
		!seen_start_r |-> !i_finished)
		else $error("o_finished before any start");

endmodule

bind rsa_core rsa_core_chk u_chk (
	.i_clk        (i_clk),
	.i_rst        (i_rst),
	.i_start      (i_start),
	.i_finished   (o_finished),
	.i_prep_start (prep_start_r),
	.i_prep_done  (prep_done),
	.i_sq_start   (sq_start_r),
	.i_sq_done    (sq_done),
	.i_mul_start  (mul_start_r),
	.i_mul_done   (mul_done)
);

// File: verif/tb_rsa.sv
`timescale 1ns/10ps

module tb_rsa;
	import rsa_pkg::*;

	logic             i_clk;
	logic             i_rst;
	logic             i_start;
	logic [RSA_W-1:0] i_a;
	logic [RSA_W-1:0] i_d;
	logic [RSA_W-1:0] i_n;
	logic [RSA_W-1:0] o_a_pow_d;
	logic             o_finished;

	logic [RSA_W-1:0] exp_mem [0:63]; // expected results in issue order
	logic [RSA_W-1:0] last_exp;
	logic [RSA_W-1:0] fix_a;
	logic [RSA_W-1:0] fix_n;
	int               issued;
	int               rd_idx;
	int               fin_cnt;        // o_finished pulses seen
	int               cmp_err;
	int               stim_err;
	int               test_cnt;
	int               bad_tests;
	int               timeout_cyc;
	int               seed;
	bit               aborted;

	rsa_core i_rsa_core (
		.i_clk      (i_clk),
		.i_rst      (i_rst),
		.i_start    (i_start),
		.i_a        (i_a),
		.i_d        (i_d),
		.i_n        (i_n),
		.o_a_pow_d  (o_a_pow_d),
		.o_finished (o_finished)
	);

	initial begin
		i_clk = 1'b0;
		forever #5 i_clk = ~i_clk;
	end

	// plain square-and-multiply, products fit in 512 bits
	function automatic logic [RSA_W-1:0] mod_exp(input logic [RSA_W-1:0] a,
		input logic [RSA_W-1:0] d, input logic [RSA_W-1:0] n);
		logic [2*RSA_W-1:0] acc;
		logic [2*RSA_W-1:0] base;
		logic [2*RSA_W-1:0] nn;
		logic [RSA_W-1:0]   dd;
		nn   = {{RSA_W{1'b0}}, n};
		acc  = {{(2*RSA_W-1){1'b0}}, 1'b1} % nn;
		base = {{RSA_W{1'b0}}, a} % nn;
		dd   = d;
		repeat (RSA_W) begin
			if (dd[0]) begin
				acc = (acc * base) % nn;
			end
			base = (base * base) % nn;
			dd   = dd >> 1;
		end
		return acc[RSA_W-1:0];
	endfunction

	function automatic logic [RSA_W-1:0] rand_wide();
		logic [RSA_W-1:0] v;
		v = '0;
		repeat (RSA_W / 32) begin
			v = {v[RSA_W-33:0], $random(seed)};
		end
		return v;
	endfunction

	// compare every completion against the oldest outstanding expectation
	always @(negedge i_clk) begin
		if (!i_rst && o_finished) begin
			fin_cnt++;
			if (rd_idx >= issued) begin
				$display("o_finished pulsed while no run was outstanding");
				cmp_err++;
			end else begin
				last_exp = exp_mem[rd_idx[5:0]];
				if (o_a_pow_d !== last_exp) begin
					$display("FAIL o_a_pow_d got 0x%h expected 0x%h", o_a_pow_d, last_exp);
					cmp_err++;
				end
			end
			rd_idx++;
		end
	end

	task automatic report(input string name, input int err0);
		int errs;
		errs = stim_err + cmp_err - err0;
		test_cnt++;
		if (errs != 0 || aborted) begin
			bad_tests++;
		end
		$display("test %s: %0d error(s)", name, errs);
	endtask

	task automatic start_run(input logic [RSA_W-1:0] a, input logic [RSA_W-1:0] d,
		input logic [RSA_W-1:0] n, input logic [RSA_W-1:0] exp);
		exp_mem[issued[5:0]] = exp;
		issued++;
		i_a     <= a;
		i_d     <= d;
		i_n     <= n;
		i_start <= 1'b1;
		@(posedge i_clk);
		i_start <= 1'b0;
	endtask

	task automatic wait_finish(input int prev, output int used);
		used = 0;
		while (fin_cnt == prev && used < timeout_cyc) begin
			@(posedge i_clk);
			used++;
		end
		if (fin_cnt == prev) begin
			$display("timeout: no o_finished within %0d cycles", timeout_cyc);
			aborted = 1'b1;
		end
	endtask

	task automatic run_test(input string name, input logic [RSA_W-1:0] a,
		input logic [RSA_W-1:0] d, input logic [RSA_W-1:0] n, input logic [RSA_W-1:0] exp);
		int prev;
		int used;
		int err0;
		if (!aborted) begin
			err0 = stim_err + cmp_err;
			prev = fin_cnt;
			start_run(a, d, n, exp);
			wait_finish(prev, used);
			report(name, err0);
		end
	endtask

	// outputs quiet until the first start
	task automatic check_idle();
		int err0;
		err0 = stim_err + cmp_err;
		repeat (20) begin
			@(negedge i_clk);
			if (o_finished !== 1'b0) begin
				$display("FAIL o_finished got 0x%h expected 0x0", o_finished);
				stim_err++;
			end
			if (o_a_pow_d !== '0) begin
				$display("FAIL o_a_pow_d got 0x%h expected 0x0", o_a_pow_d);
				stim_err++;
			end
		end
		@(posedge i_clk);
		report("idle", err0);
	endtask

	task automatic hold_check(input logic [RSA_W-1:0] exp);
		int err0;
		if (!aborted) begin
			err0 = stim_err + cmp_err;
			repeat (50) begin
				@(negedge i_clk);
				if (o_a_pow_d !== exp) begin
					$display("FAIL o_a_pow_d got 0x%h expected 0x%h", o_a_pow_d, exp);
					stim_err++;
				end
				if (o_finished !== 1'b0) begin
					$display("FAIL o_finished got 0x%h expected 0x0", o_finished);
					stim_err++;
				end
			end
			@(posedge i_clk);
			report("hold", err0);
		end
	endtask

	task automatic random_test(input int k);
		logic [RSA_W-1:0] a;
		logic [RSA_W-1:0] d;
		logic [RSA_W-1:0] n;
		n    = rand_wide();
		n[0] = 1'b1; // modulus must be odd
		a    = rand_wide() % n;
		d    = rand_wide();
		run_test($sformatf("random_%0d", k), a, d, n, mod_exp(a, d, n));
	endtask

	task automatic back_to_back_test();
		logic [RSA_W-1:0] a1, d1, n1, a2, d2, n2, exp2;
		int prev;
		int used;
		int err0;
		n1    = rand_wide() | RSA_W'(1);
		a1    = rand_wide() % n1;
		d1    = rand_wide();
		n2    = rand_wide() | RSA_W'(1);
		a2    = rand_wide() % n2;
		d2    = rand_wide();
		exp2  = mod_exp(a2, d2, n2);
		if (!aborted) begin
			err0 = stim_err + cmp_err;
			prev = fin_cnt;
			start_run(a1, d1, n1, mod_exp(a1, d1, n1));
			wait_finish(prev, used);
			if (!aborted) begin
				start_run(a2, d2, n2, exp2); // strobe in the cycle after o_finished
				wait_finish(prev + 1, used);
			end
			report("back_to_back", err0);
			hold_check(exp2);
		end
	endtask

	task automatic busy_start_test();
		logic [RSA_W-1:0] a, d, n;
		int prev;
		int used;
		int err0;
		n = rand_wide() | RSA_W'(1);
		a = rand_wide() % n;
		d = rand_wide();
		if (!aborted) begin
			err0 = stim_err + cmp_err;
			prev = fin_cnt;
			start_run(a, d, n, mod_exp(a, d, n));
			repeat (400) @(posedge i_clk); // well into the exponent loop
			i_a     <= rand_wide() % n;
			i_d     <= ~d;
			i_start <= 1'b1;
			@(posedge i_clk);
			i_start <= 1'b0;
			wait_finish(prev, used);
			repeat (timeout_cyc - used) @(posedge i_clk);
			if (!aborted && fin_cnt != prev + 1) begin
				$display("the ignored start produced an extra o_finished pulse");
				stim_err++;
			end
			report("busy_start", err0);
		end
	endtask

	initial begin
		seed        = 67;
		timeout_cyc = 80000;
		aborted     = 1'b0;
		issued      = 0;
		stim_err    = 0;
		test_cnt    = 0;
		bad_tests   = 0;
		fix_n       = 256'hE3B0C44298FC1C149AFBF4C8996FB92427AE41E4649B934CA495991B7852B855;
		fix_a       = 256'h0123456789ABCDEFFEDCBA98765432100F1E2D3C4B5A69788796A5B4C3D2E1F0;
		i_rst   <= 1'b1;
		i_start <= 1'b0;
		i_a     <= '0;
		i_d     <= '0;
		i_n     <= '0;
		repeat (5) @(posedge i_clk);
		i_rst <= 1'b0;

		check_idle();
		run_test("d_zero", fix_a, '0, fix_n, RSA_W'(1));
		run_test("d_one", fix_a, RSA_W'(1), fix_n, fix_a);
		run_test("d_two", fix_a, RSA_W'(2), fix_n, mod_exp(fix_a, RSA_W'(2), fix_n));
		run_test("d_all_ones", fix_a, '1, fix_n, mod_exp(fix_a, '1, fix_n));
		for (int k = 0; k < 8; k++) begin
			random_test(k);
		end
		back_to_back_test();
		busy_start_test();

		$display("summary: %0d tests, %0d with errors, %0d errors", test_cnt, bad_tests,
			stim_err + cmp_err);
		if (aborted || bad_tests != 0 || stim_err + cmp_err != 0) begin
			$display("tests failed");
		end else begin
			$display("all tests passed");
		end
		$finish;
	end

	initial begin
		rd_idx  = 0;
		fin_cnt = 0;
		cmp_err = 0;
	end

endmodule

// File: files.f
source/rsa_pkg.sv
source/rsa_mod_prep.sv
source/rsa_mont_mult.sv
source/rsa_core.sv
verif/rsa_core_chk.sv
verif/tb_rsa.sv

// File: run.sh
#!/bin/sh
# build and run the rsa core testbench with verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert \
	--top-module tb_rsa \
	-f files.f

./obj_dir/Vtb_rsa > sim.log 2>&1 || true
cat sim.log

if grep -qx "all tests passed" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
